// ==== filelist.f ====
logic/soc_pkg.sv
logic/wb_decoder.sv
logic/wb_bram.sv
logic/wb_timer.sv
logic/wb_gpio.sv
logic/board_io.sv
logic/soc_top.sv
tb/tb_soc_top.sv

// ==== tb/tb_soc_top.sv ====
// testbench for the wishbone peripheral subsystem
// drives the slave port as bus master, predicts ram, led, gpio and irq values
`timescale 1ns/10ps

module tb_soc_top;
	import soc_pkg::*;

	localparam int ACK_TIMEOUT = 16;
	localparam int IRQ_TIMEOUT = 200;

	logic  clk = 1'b0;
	logic  rst_n_i;
	word_t wb_adr_i;
	word_t wb_dat_i;
	sel_t  wb_sel_i;
	logic  wb_we_i;
	logic  wb_cyc_i;
	logic  wb_stb_i;
	btn_t  btn_i;
	sw_t   sw_i;
	rot_t  rot_i;
	word_t wb_dat_o;
	logic  wb_ack_o;
	word_t irq_n_o;
	led_t  led_o;

	// reference state and bookkeeping
	word_t     shadow [BRAM_WORDS];
	bram_adr_t ram_idx [16];
	int        errors = 0;
	int        checks = 0;
	int        tests_run = 0;
	int        tests_failed = 0;
	int        test_err_base = 0;

	soc_top uut (
		.clk(clk), .rst_n_i(rst_n_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
		.btn_i(btn_i), .sw_i(sw_i), .rot_i(rot_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .irq_n_o(irq_n_o), .led_o(led_o)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	// debug pattern top down: reset, cyc, stb, ack, t1, gpio, t0, 0
	function automatic led_t predict_led(input sw_t sw, input word_t gout, input logic rst_act,
			input logic cyc, input logic stb, input logic ack,
			input logic t0, input logic gp, input logic t1);
		if (sw[1]) begin
			return gout[7:0];
		end
		return {rst_act, cyc, stb, ack, t1, gp, t0, 1'b0};
	endfunction

	function automatic word_t predict_gpio_in(input sw_t sw, input btn_t btn, input rot_t rot);
		word_t w;
		w = '0;
		if (sw[1]) begin
			w = word_t'({rot, btn}) << 8;
		end
		return w;
	endfunction

	// active low vector, uart bit never asserted
	function automatic word_t predict_irq_n(input logic t0, input logic gp, input logic t1);
		word_t v;
		v             = '1;
		v[IRQ_TIMER0] = !t0;
		v[IRQ_GPIO]   = !gp;
		v[IRQ_TIMER1] = !t1;
		return v;
	endfunction

	function automatic word_t ram_fill(input bram_adr_t idx);
		return 32'hc3a5_0000 ^ {12'h0, idx, idx};
	endfunction

	// alias bits 16..12 land inside the same 4 KB window
	function automatic word_t ram_addr(input bram_adr_t idx, input logic [4:0] alias_bits);
		return {REGION_BRAM, alias_bits, idx, 2'b00};
	endfunction

	function automatic word_t tmr_addr(input logic [2:0] ofs);
		return {REGION_TIMER, 12'h0, ofs, 2'b00};
	endfunction

	function automatic word_t gpio_addr(input logic [1:0] ofs);
		return {REGION_GPIO, 13'h0, ofs, 2'b00};
	endfunction

	// ------------------------------------------------------------------
	// checks and report
	// ------------------------------------------------------------------
	task automatic check_word(input word_t act, input word_t exp, input string what);
		checks++;
		if (act !== exp) begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, act, exp);
			errors++;
		end
	endtask

	task automatic check_led(input led_t act, input led_t exp, input string what);
		checks++;
		if (act !== exp) begin
			$display("[FAIL] %0t ns: %s got %b expected %b", $time, what, act, exp);
			errors++;
		end
	endtask

	task automatic start_test();
		test_err_base = errors;
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
			tests_failed++;
		end
	endtask

	// ------------------------------------------------------------------
	// bus master
	// ------------------------------------------------------------------
	// one classic cycle, ack expected one clock after the request
	task automatic bus_cycle(input word_t adr, input word_t dat, input sel_t sel,
			input logic we, output word_t rdat);
		int   n;
		logic got;
		@(posedge clk);
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		wb_we_i  <= we;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		n    = 0;
		got  = 1'b0;
		rdat = '0;
		while (!got && n < ACK_TIMEOUT) begin
			@(negedge clk);
			if (wb_ack_o === 1'b1) begin
				got  = 1'b1;
				rdat = wb_dat_o;
			end else begin
				n++;
			end
		end
		if (got) begin
			check_word(word_t'(n), 32'd1, "ack latency");
		end else begin
			$display("bus timeout at %0t ns: no ack for address %h", $time, adr);
			errors++;
		end
		@(posedge clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic bus_write(input word_t adr, input word_t dat, input sel_t sel);
		word_t unused;
		bus_cycle(adr, dat, sel, 1'b1, unused);
	endtask

	task automatic bus_read(input word_t adr, output word_t rdat);
		bus_cycle(adr, '0, 4'hf, 1'b0, rdat);
	endtask

	task automatic wait_irq_level(input int pos, input logic level, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (irq_n_o[pos] !== level && n < IRQ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (irq_n_o[pos] !== level) begin
			$display("timeout at %0t ns: %s never reached level %b", $time, what, level);
			errors++;
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (led_o[7] !== 1'b0 && n < IRQ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (led_o[7] !== 1'b0) begin
			$display("timeout at %0t ns: button reset did not release", $time);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		word_t      rd;
		word_t      wdat;
		word_t      gout;
		sel_t       wsel;
		bram_adr_t  idx;
		btn_t       bval;
		rot_t       rval;
		int unsigned seed_out;

		seed_out = $urandom(32'h6fe7_7990);
		rst_n_i  = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		wb_we_i  = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		btn_i    = '0;
		sw_i     = '0;
		rot_i    = '0;
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;

		// 1: state one cycle after release
		start_test();
		@(posedge clk);
		@(negedge clk);
		check_word(irq_n_o, predict_irq_n(0, 0, 0), "irq vector after reset");
		check_word(word_t'(wb_ack_o), 32'd0, "ack after reset");
		check_led(led_o, predict_led(sw_i, '0, 0, 0, 0, 0, 0, 0, 0), "debug leds after reset");
		finish_test("reset state");

		// 2: ram, full fill then random byte lane writes
		start_test();
		for (int k = 0; k < 16; k++) begin
			ram_idx[k] = bram_adr_t'(k * 67);
			shadow[ram_idx[k]] = ram_fill(ram_idx[k]);
			bus_write(ram_addr(ram_idx[k], 5'h0), shadow[ram_idx[k]], 4'hf);
		end
		for (int k = 0; k < 64; k++) begin
			idx  = ram_idx[$urandom_range(15, 0)];
			wdat = $urandom;
			wsel = sel_t'($urandom);
			for (int b = 0; b < 4; b++) begin
				if (wsel[b]) begin
					shadow[idx][8*b +: 8] = wdat[8*b +: 8];
				end
			end
			bus_write(ram_addr(idx, 5'($urandom)), wdat, wsel);
		end
		for (int k = 0; k < 16; k++) begin
			bus_read(ram_addr(ram_idx[k], 5'($urandom)), rd);
			check_word(rd, shadow[ram_idx[k]], "ram readback");
		end
		finish_test("ram random access");

		// 3: unmapped window
		start_test();
		bus_read(32'hf000_0000, rd);
		check_word(rd, 32'h0, "unmapped read");
		finish_test("unmapped read");

		// 4: timer0 auto-reload, timer1 one shot
		start_test();
		bus_write(tmr_addr(TMR_CMP0), 32'd20, 4'hf);
		bus_write(tmr_addr(TMR_CTRL0), (1 << CTRL_EN) | (1 << CTRL_AR), 4'hf);
		wait_irq_level(IRQ_TIMER0, 1'b0, "timer0 irq");
		bus_write(tmr_addr(TMR_CTRL0), (1 << CTRL_EN) | (1 << CTRL_AR) | (1 << CTRL_TRIG), 4'hf);
		@(negedge clk);
		check_word(irq_n_o, predict_irq_n(0, 0, 0), "irq after trigger clear");
		wait_irq_level(IRQ_TIMER0, 1'b0, "timer0 irq after reload");
		// stop timer0 and drop its flag
		bus_write(tmr_addr(TMR_CTRL0), 1 << CTRL_TRIG, 4'hf);
		bus_write(tmr_addr(TMR_CMP1), 32'd10, 4'hf);
		bus_write(tmr_addr(TMR_CTRL1), 1 << CTRL_EN, 4'hf);
		wait_irq_level(IRQ_TIMER1, 1'b0, "timer1 irq");
		bus_read(tmr_addr(TMR_CTRL1), rd);
		// flag set, enable dropped
		check_word(rd, 1 << CTRL_TRIG, "timer1 control after one shot");
		bus_write(tmr_addr(TMR_CTRL1), 1 << CTRL_TRIG, 4'hf);
		@(negedge clk);
		check_word(irq_n_o, predict_irq_n(0, 0, 0), "irq after timers stopped");
		finish_test("timers");

		// 5: gpio mode, inputs, leds and masked irq
		start_test();
		for (int k = 0; k < 2; k++) begin
			bval = btn_t'($urandom);
			rval = rot_t'($urandom);
			if (k == 1) begin
				bval[0] = 1'b1;
			end
			@(posedge clk);
			sw_i  <= 4'b0010;
			btn_i <= bval;
			rot_i <= rval;
			// input synchronizer depth
			repeat (3) @(posedge clk);
			bus_read(gpio_addr(GPIO_IN), rd);
			check_word(rd, predict_gpio_in(4'b0010, bval, rval), "gpio input word");
		end
		gout = $urandom;
		bus_write(gpio_addr(GPIO_OUT), gout, 4'hf);
		@(negedge clk);
		check_led(led_o, predict_led(sw_i, gout, 0, 0, 0, 0, 0, 0, 0), "gpio leds");
		// upper lanes only, leds keep their value
		bus_write(gpio_addr(GPIO_OUT), ~gout, 4'b1110);
		gout[31:8] = ~gout[31:8];
		bus_read(gpio_addr(GPIO_OUT), rd);
		check_word(rd, gout, "gpio out lane write");
		check_led(led_o, predict_led(sw_i, gout, 0, 0, 0, 0, 0, 0, 0), "leds after lane write");
		bus_write(gpio_addr(GPIO_MASK), 32'h0000_0100, 4'hf);
		@(negedge clk);
		check_word(irq_n_o, predict_irq_n(0, 1, 0), "gpio irq with btn0 masked in");
		finish_test("gpio");

		// 6: button reset in debug mode
		start_test();
		bus_write(gpio_addr(GPIO_OE), 32'h0000_00ff, 4'hf);
		bus_write(tmr_addr(TMR_CMP0), 32'd1000, 4'hf);
		bus_write(tmr_addr(TMR_CTRL0), 1 << CTRL_EN, 4'hf);
		@(posedge clk);
		sw_i  <= 4'b0000;
		btn_i <= 4'b0001;
		@(posedge clk);
		@(posedge clk);
		btn_i <= 4'b0000;
		@(negedge clk);
		check_led(led_o, predict_led(4'b0000, '0, 1, 0, 0, 0, 0, 0, 0), "leds during reset");
		wait_reset_release();
		bus_read(gpio_addr(GPIO_OUT), rd);
		check_word(rd, 32'h0, "gpio out after button reset");
		bus_read(gpio_addr(GPIO_OE), rd);
		check_word(rd, 32'h0, "gpio oe after button reset");
		bus_read(gpio_addr(GPIO_MASK), rd);
		check_word(rd, 32'h0, "gpio mask after button reset");
		bus_read(tmr_addr(TMR_CTRL0), rd);
		check_word(rd, 32'h0, "timer0 control after button reset");
		bus_read(tmr_addr(TMR_CMP0), rd);
		check_word(rd, 32'h0, "timer0 compare after button reset");
		bus_read(tmr_addr(TMR_CNT0), rd);
		check_word(rd, 32'h0, "timer0 counter after button reset");
		check_word(irq_n_o, predict_irq_n(0, 0, 0), "irq vector after button reset");
		finish_test("button reset");

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== logic/soc_top.sv ====
// wishbone peripheral subsystem top
// decoder, block ram, timer, gpio and board glue behind one slave port
`timescale 1ns/10ps

module soc_top (
	input  logic          clk,
	input  logic          rst_n_i,
	input  soc_pkg::word_t wb_adr_i,
	input  soc_pkg::word_t wb_dat_i,
	input  soc_pkg::sel_t  wb_sel_i,
	input  logic          wb_we_i,
	input  logic          wb_cyc_i,
	input  logic          wb_stb_i,
	input  soc_pkg::btn_t  btn_i,
	input  soc_pkg::sw_t   sw_i,
	input  soc_pkg::rot_t  rot_i,
	output soc_pkg::word_t wb_dat_o,
	output logic          wb_ack_o,
	output soc_pkg::word_t irq_n_o,
	output soc_pkg::led_t  led_o
);
	import soc_pkg::*;

	logic       sys_rst_n;
	logic       bram_stb, timer_stb, gpio_stb;
	logic       bram_ack, timer_ack, gpio_ack;
	word_t      bram_dat, timer_dat, gpio_dat;
	word_t      gpio_in, gpio_out;
	logic [1:0] timer_irq;
	logic       gpio_irq;

	// ------------------------------------------------------------------
	// interconnect
	// ------------------------------------------------------------------
	wb_decoder dec0 (
		.clk(clk), .rst_n_i(sys_rst_n), .adr_i(wb_adr_i),
		.cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
		.bram_stb_o(bram_stb), .timer_stb_o(timer_stb), .gpio_stb_o(gpio_stb),
		.bram_dat_i(bram_dat), .timer_dat_i(timer_dat), .gpio_dat_i(gpio_dat),
		.bram_ack_i(bram_ack), .timer_ack_i(timer_ack), .gpio_ack_i(gpio_ack),
		.dat_o(wb_dat_o), .ack_o(wb_ack_o)
	);

	// ------------------------------------------------------------------
	// slaves
	// ------------------------------------------------------------------
	// word index, wraps inside the 4 KB window
	wb_bram bram0 (
		.clk(clk), .rst_n_i(sys_rst_n), .adr_i(wb_adr_i[11:2]),
		.dat_i(wb_dat_i), .sel_i(wb_sel_i), .we_i(wb_we_i),
		.cyc_i(wb_cyc_i), .stb_i(bram_stb),
		.dat_o(bram_dat), .ack_o(bram_ack)
	);

	wb_timer timer0 (
		.clk(clk), .rst_n_i(sys_rst_n), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
		.we_i(wb_we_i), .cyc_i(wb_cyc_i), .stb_i(timer_stb),
		.dat_o(timer_dat), .ack_o(timer_ack), .irq_o(timer_irq)
	);

	wb_gpio gpio0 (
		.clk(clk), .rst_n_i(sys_rst_n), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
		.sel_i(wb_sel_i), .we_i(wb_we_i), .cyc_i(wb_cyc_i), .stb_i(gpio_stb),
		.gpio_in_i(gpio_in), .dat_o(gpio_dat), .ack_o(gpio_ack),
		.gpio_out_o(gpio_out), .gpio_oe_o(), .irq_o(gpio_irq)
	);

	// board glue, the only user of the raw reset
	board_io io0 (
		.clk(clk), .rst_n_i(rst_n_i), .btn_i(btn_i), .sw_i(sw_i), .rot_i(rot_i),
		.gpio_out_i(gpio_out), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .ack_i(wb_ack_o),
		.irq_i({timer_irq[1], gpio_irq, timer_irq[0]}),
		.sys_rst_n_o(sys_rst_n), .gpio_in_o(gpio_in), .led_o(led_o)
	);

	// ------------------------------------------------------------------
	// active low interrupt vector
	// ------------------------------------------------------------------
	always_comb begin
		irq_n_o             = '1;
		// no uart here, bit held inactive
		irq_n_o[IRQ_UART]   = 1'b1;
		irq_n_o[IRQ_TIMER0] = !timer_irq[0];
		irq_n_o[IRQ_GPIO]   = !gpio_irq;
		irq_n_o[IRQ_TIMER1] = !timer_irq[1];
	end

endmodule

// ==== logic/board_io.sv ====
// board glue
// button reset, sw[1] routing of leds and buttons to gpio, debug leds
`timescale 1ns/10ps

module board_io (
	input  logic          clk,
	input  logic          rst_n_i,
	input  soc_pkg::btn_t  btn_i,
	input  soc_pkg::sw_t   sw_i,
	input  soc_pkg::rot_t  rot_i,
	input  soc_pkg::word_t gpio_out_i,
	input  logic          cyc_i,
	input  logic          stb_i,
	input  logic          ack_i,
	// timer0, gpio, timer1 from bit 0 up
	input  logic [2:0]    irq_i,
	output logic          sys_rst_n_o,
	output soc_pkg::word_t gpio_in_o,
	output soc_pkg::led_t  led_o
);
	import soc_pkg::*;

	logic gpio_mode;
	logic btn_rst;
	led_t debug_leds;

	// sw[1] high: board io belongs to gpio
	assign gpio_mode = sw_i[1];
	// btn[0] is a reset only in debug mode
	assign btn_rst   = !gpio_mode && btn_i[0];

	// registered system reset
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			sys_rst_n_o <= 1'b0;
		end else begin
			sys_rst_n_o <= !btn_rst;
		end
	end

	// ------------------------------------------------------------------
	// led and gpio input muxing
	// ------------------------------------------------------------------
	assign debug_leds = {!sys_rst_n_o, cyc_i, stb_i, ack_i, irq_i[2], irq_i[1], irq_i[0], 1'b0};
	assign led_o      = gpio_mode ? gpio_out_i[7:0] : debug_leds;

	always_comb begin
		gpio_in_o = '0;
		// rot and btn land on bits 14..8
		if (gpio_mode) begin
			gpio_in_o[14:8] = {rot_i, btn_i};
		end
	end

endmodule

// ==== logic/wb_gpio.sv ====
// wishbone gpio
// two-flop input sync, byte writable out/oe/mask, masked input irq
`timescale 1ns/10ps

module wb_gpio (
	input  logic          clk,
	input  logic          rst_n_i,
	input  soc_pkg::word_t adr_i,
	input  soc_pkg::word_t dat_i,
	input  soc_pkg::sel_t  sel_i,
	input  logic          we_i,
	input  logic          cyc_i,
	input  logic          stb_i,
	input  soc_pkg::word_t gpio_in_i,
	output soc_pkg::word_t dat_o,
	output logic          ack_o,
	output soc_pkg::word_t gpio_out_o,
	output soc_pkg::word_t gpio_oe_o,
	output logic          irq_o
);
	import soc_pkg::*;

	word_t      in_meta_q;
	word_t      in_sync_q;
	word_t      mask_q;
	logic       req;
	logic       wr;
	logic [1:0] ofs;

	// merge write data by byte lane
	function automatic word_t lane_merge(input word_t old_w, input word_t new_w, input sel_t sel);
		word_t w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return w;
	endfunction

	assign req = cyc_i && stb_i && !ack_o;
	assign wr  = req && we_i;
	assign ofs = adr_i[3:2];

	// input synchronizer
	always_ff @(posedge clk) begin
		in_meta_q <= gpio_in_i;
		in_sync_q <= in_meta_q;
	end

	// ------------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ack_o      <= 1'b0;
			gpio_out_o <= '0;
			gpio_oe_o  <= '0;
			mask_q     <= '0;
		end else begin
			ack_o <= req;
			if (wr) begin
				// GPIO_IN writes are dropped
				case (ofs)
					GPIO_OUT:  gpio_out_o <= lane_merge(gpio_out_o, dat_i, sel_i);
					GPIO_OE:   gpio_oe_o  <= lane_merge(gpio_oe_o, dat_i, sel_i);
					GPIO_MASK: mask_q     <= lane_merge(mask_q, dat_i, sel_i);
					default:   ;
				endcase
			end
		end
	end

	// readback
	always_ff @(posedge clk) begin
		if (req) begin
			case (ofs)
				GPIO_IN:   dat_o <= in_sync_q;
				GPIO_OUT:  dat_o <= gpio_out_o;
				GPIO_OE:   dat_o <= gpio_oe_o;
				default:   dat_o <= mask_q;
			endcase
		end
	end

	// level irq, any enabled input high
	assign irq_o = |(in_sync_q & mask_q);

endmodule

// ==== logic/wb_timer.sv ====
// dual compare timer on wishbone
// per timer: control, compare and counter registers,
// trigger flag drives the interrupt, optional auto-reload
`timescale 1ns/10ps

module wb_timer (
	input  logic          clk,
	input  logic          rst_n_i,
	input  soc_pkg::word_t adr_i,
	input  soc_pkg::word_t dat_i,
	input  logic          we_i,
	input  logic          cyc_i,
	input  logic          stb_i,
	output soc_pkg::word_t dat_o,
	output logic          ack_o,
	output logic [1:0]    irq_o
);
	import soc_pkg::*;

	logic [1:0] en_q;
	logic [1:0] ar_q;
	logic [1:0] trig_q;
	word_t      cmp_q [2];
	word_t      cnt_q [2];

	logic       req;
	logic       wr;
	logic [2:0] ofs;
	logic [1:0] wr_ctrl;
	logic [1:0] wr_cmp;
	logic [1:0] wr_cnt;

	// control word as seen on the bus
	function automatic word_t ctrl_word(input logic en, input logic ar, input logic trig);
		word_t w;
		w            = '0;
		w[CTRL_EN]   = en;
		w[CTRL_AR]   = ar;
		w[CTRL_TRIG] = trig;
		return w;
	endfunction

	assign req = cyc_i && stb_i && !ack_o;
	assign wr  = req && we_i;
	assign ofs = adr_i[4:2];

	// register write strobes
	assign wr_ctrl[0] = wr && (ofs == TMR_CTRL0);
	assign wr_cmp[0]  = wr && (ofs == TMR_CMP0);
	assign wr_cnt[0]  = wr && (ofs == TMR_CNT0);
	assign wr_ctrl[1] = wr && (ofs == TMR_CTRL1);
	assign wr_cmp[1]  = wr && (ofs == TMR_CMP1);
	assign wr_cnt[1]  = wr && (ofs == TMR_CNT1);

	// ------------------------------------------------------------------
	// counters and register bank
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ack_o  <= 1'b0;
			en_q   <= '0;
			ar_q   <= '0;
			trig_q <= '0;
			for (int i = 0; i < 2; i++) begin
				cmp_q[i] <= '0;
				cnt_q[i] <= '0;
			end
		end else begin
			ack_o <= req;
			for (int i = 0; i < 2; i++) begin
				// flag clear first, a match in the same cycle still sets it
				if (wr_ctrl[i] && dat_i[CTRL_TRIG]) begin
					trig_q[i] <= 1'b0;
				end
				if (en_q[i]) begin
					if (cnt_q[i] == cmp_q[i]) begin
						trig_q[i] <= 1'b1;
						if (ar_q[i]) begin
							cnt_q[i] <= '0;
						end else begin
							// one shot, stop here
							en_q[i] <= 1'b0;
						end
					end else begin
						cnt_q[i] <= cnt_q[i] + 32'd1;
					end
				end
				// bus writes win over the counter logic
				if (wr_ctrl[i]) begin
					en_q[i] <= dat_i[CTRL_EN];
					ar_q[i] <= dat_i[CTRL_AR];
				end
				if (wr_cmp[i]) begin
					cmp_q[i] <= dat_i;
				end
				if (wr_cnt[i]) begin
					cnt_q[i] <= dat_i;
				end
			end
		end
	end

	// readback, sampled at the request edge
	always_ff @(posedge clk) begin
		if (req) begin
			case (ofs)
				TMR_CTRL0: dat_o <= ctrl_word(en_q[0], ar_q[0], trig_q[0]);
				TMR_CMP0:  dat_o <= cmp_q[0];
				TMR_CNT0:  dat_o <= cnt_q[0];
				TMR_CTRL1: dat_o <= ctrl_word(en_q[1], ar_q[1], trig_q[1]);
				TMR_CMP1:  dat_o <= cmp_q[1];
				TMR_CNT1:  dat_o <= cnt_q[1];
				default:   dat_o <= '0;
			endcase
		end
	end

	// interrupt is the trigger flag itself
	assign irq_o = trig_q;

endmodule

// ==== logic/wb_bram.sv ====
// wishbone block ram, 1024 x 32
// byte lane writes, registered read, one cycle ack
`timescale 1ns/10ps

module wb_bram (
	input  logic              clk,
	input  logic              rst_n_i,
	input  soc_pkg::bram_adr_t adr_i,
	input  soc_pkg::word_t    dat_i,
	input  soc_pkg::sel_t     sel_i,
	input  logic              we_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	output soc_pkg::word_t    dat_o,
	output logic              ack_o
);
	import soc_pkg::*;

	word_t mem [BRAM_WORDS];
	logic  req;

	// new request, never while ack is up
	assign req = cyc_i && stb_i && !ack_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

	// ------------------------------------------------------------------
	// memory array
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (req) begin
			// read before write, data valid while ack high
			dat_o <= mem[adr_i];
			if (we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

// ==== logic/wb_decoder.sv ====
// wishbone address decoder
// routes stb by address window, steers read data and ack back,
// acks unmapped cycles with zero data
`timescale 1ns/10ps

module wb_decoder (
	input  logic          clk,
	input  logic          rst_n_i,
	input  soc_pkg::word_t adr_i,
	input  logic          cyc_i,
	input  logic          stb_i,
	// per slave strobes
	output logic          bram_stb_o,
	output logic          timer_stb_o,
	output logic          gpio_stb_o,
	// slave returns
	input  soc_pkg::word_t bram_dat_i,
	input  soc_pkg::word_t timer_dat_i,
	input  soc_pkg::word_t gpio_dat_i,
	input  logic          bram_ack_i,
	input  logic          timer_ack_i,
	input  logic          gpio_ack_i,
	// back to the master
	output soc_pkg::word_t dat_o,
	output logic          ack_o
);
	import soc_pkg::*;

	region_t region;
	logic    hit_bram;
	logic    hit_timer;
	logic    hit_gpio;
	logic    unmapped;
	logic    unm_ack_q;

	// window compare on the high address bits
	assign region    = adr_i[31:17];
	assign hit_bram  = (region == REGION_BRAM);
	assign hit_timer = (region == REGION_TIMER);
	assign hit_gpio  = (region == REGION_GPIO);
	assign unmapped  = !(hit_bram || hit_timer || hit_gpio);

	// at most one slave sees stb
	assign bram_stb_o  = stb_i && hit_bram;
	assign timer_stb_o = stb_i && hit_timer;
	assign gpio_stb_o  = stb_i && hit_gpio;

	// ------------------------------------------------------------------
	// unmapped answer, same one-cycle ack as the slaves
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			unm_ack_q <= 1'b0;
		end else begin
			unm_ack_q <= cyc_i && stb_i && unmapped && !unm_ack_q;
		end
	end

	// return steering
	always_comb begin
		if (hit_bram) begin
			dat_o = bram_dat_i;
			ack_o = bram_ack_i;
		end else if (hit_timer) begin
			dat_o = timer_dat_i;
			ack_o = timer_ack_i;
		end else if (hit_gpio) begin
			dat_o = gpio_dat_i;
			ack_o = gpio_ack_i;
		end else begin
			// nothing there, reads as zero
			dat_o = '0;
			ack_o = unm_ack_q;
		end
	end

endmodule

// ==== logic/soc_pkg.sv ====
// soc peripheral subsystem definitions
// address windows, register offsets, bus widths and interrupt vector layout
package soc_pkg;

	// ------------------------------------------------------------------
	// bus and board widths
	// ------------------------------------------------------------------
	typedef logic [31:0] word_t;
	typedef logic [3:0]  sel_t;
	// address bits 31..17, picks the slave window
	typedef logic [14:0] region_t;
	typedef logic [9:0]  bram_adr_t;
	typedef logic [7:0]  led_t;
	typedef logic [3:0]  btn_t;
	typedef logic [3:0]  sw_t;
	typedef logic [2:0]  rot_t;

	// ------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------
	localparam region_t REGION_BRAM  = 15'h0000;
	// 0xe002_0000
	localparam region_t REGION_TIMER = 15'h7001;
	// 0xe004_0000
	localparam region_t REGION_GPIO  = 15'h7002;
	localparam int      BRAM_WORDS   = 1024;

	// timer word offsets, adr[4:2]
	localparam logic [2:0] TMR_CTRL0 = 3'd0;
	localparam logic [2:0] TMR_CMP0  = 3'd1;
	localparam logic [2:0] TMR_CNT0  = 3'd2;
	localparam logic [2:0] TMR_CTRL1 = 3'd3;
	localparam logic [2:0] TMR_CMP1  = 3'd4;
	localparam logic [2:0] TMR_CNT1  = 3'd5;

	// timer control bits
	localparam int CTRL_EN   = 0;
	localparam int CTRL_AR   = 1;
	// write 1 to clear
	localparam int CTRL_TRIG = 2;

	// gpio word offsets, adr[3:2]
	localparam logic [1:0] GPIO_IN   = 2'd0;
	localparam logic [1:0] GPIO_OUT  = 2'd1;
	localparam logic [1:0] GPIO_OE   = 2'd2;
	localparam logic [1:0] GPIO_MASK = 2'd3;

	// interrupt vector bits, all others held high
	localparam int IRQ_UART   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_GPIO   = 2;
	localparam int IRQ_TIMER1 = 3;

endpackage
